// ==== Bender.yml ====
package:
  name: vga_controller

sources:
  - source/vgaRegPkg.sv
  - source/vgaPixelPkg.sv
  - source/configRegisters.sv
  - source/scanCounter.sv
  - source/syncFsm.sv
  - source/pixelAddressGen.sv
  - source/pixelOutput.sv
  - source/vgaController.sv
  - target: test
    files:
      - tb/vgaClockGen.sv
      - tb/vgaController_assert.sv
      - tb/vgaControllerTb.sv

// ==== compile.f ====
source/vgaRegPkg.sv
source/vgaPixelPkg.sv
source/configRegisters.sv
source/scanCounter.sv
source/syncFsm.sv
source/pixelAddressGen.sv
source/pixelOutput.sv
source/vgaController.sv
tb/vgaClockGen.sv
tb/vgaController_assert.sv
tb/vgaControllerTb.sv

// ==== source/configRegisters.sv ====
`timescale 1ns/10ps
`default_nettype none

module configRegisters (
	input wire vga_clk,
	input wire rstN,
	input wire busWe,
	input wire busOe,
	input wire [23:0] busAddress,
	input wire [3:0] busByteSelect,
	input wire [31:0] busDataWrite,
	output logic [31:0] busDataRead,
	output logic requestOutput,
	output logic [vgaRegPkg::H_WIDTH-1:0] hVisibleCmp,
	output logic [vgaRegPkg::H_WIDTH-1:0] hFrontCmp,
	output logic [vgaRegPkg::H_WIDTH-1:0] hSyncCmp,
	output logic [vgaRegPkg::H_WIDTH-1:0] hWholeCmp,
	output logic [vgaRegPkg::V_WIDTH-1:0] vVisibleCmp,
	output logic [vgaRegPkg::V_WIDTH-1:0] vFrontCmp,
	output logic [vgaRegPkg::V_WIDTH-1:0] vSyncCmp,
	output logic [vgaRegPkg::V_WIDTH-1:0] vWholeCmp,
	output logic [3:0] horizontalPixelSize,
	output logic [3:0] verticalPixelSize,
	output logic [1:0] drawMode
);
	localparam int HW = vgaRegPkg::H_WIDTH;
	localparam int VW = vgaRegPkg::V_WIDTH;

	logic blockSelected;
	logic [11:0] regOffset;
	logic [31:0] writeMask;
	logic regHit;
	logic [31:0] readValue;
	vgaRegPkg::configWord_u configWord;

	// Keep the lanes that are not selected
	function automatic logic [31:0] mergeWrite(input logic [31:0] current);
		return (current & ~writeMask) | (busDataWrite & writeMask);
	endfunction

	assign blockSelected = busAddress[23:12] == vgaRegPkg::CONFIG_BASE;
	assign regOffset = busAddress[11:0];
	assign writeMask = {{8{busByteSelect[3]}}, {8{busByteSelect[2]}},
		{8{busByteSelect[1]}}, {8{busByteSelect[0]}}};

	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			hVisibleCmp <= vgaRegPkg::DEFAULT_H_VISIBLE;
			hFrontCmp <= vgaRegPkg::DEFAULT_H_FRONT;
			hSyncCmp <= vgaRegPkg::DEFAULT_H_SYNC;
			hWholeCmp <= vgaRegPkg::DEFAULT_H_WHOLE;
			vVisibleCmp <= vgaRegPkg::DEFAULT_V_VISIBLE;
			vFrontCmp <= vgaRegPkg::DEFAULT_V_FRONT;
			vSyncCmp <= vgaRegPkg::DEFAULT_V_SYNC;
			vWholeCmp <= vgaRegPkg::DEFAULT_V_WHOLE;
			configWord.raw <= vgaRegPkg::DEFAULT_CONFIG;
		end else if (busWe && blockSelected) begin
			case (regOffset)
				vgaRegPkg::REG_H_VISIBLE: hVisibleCmp <= HW'(mergeWrite(32'(hVisibleCmp)));
				vgaRegPkg::REG_H_FRONT: hFrontCmp <= HW'(mergeWrite(32'(hFrontCmp)));
				vgaRegPkg::REG_H_SYNC: hSyncCmp <= HW'(mergeWrite(32'(hSyncCmp)));
				vgaRegPkg::REG_H_WHOLE: hWholeCmp <= HW'(mergeWrite(32'(hWholeCmp)));
				vgaRegPkg::REG_V_VISIBLE: vVisibleCmp <= VW'(mergeWrite(32'(vVisibleCmp)));
				vgaRegPkg::REG_V_FRONT: vFrontCmp <= VW'(mergeWrite(32'(vFrontCmp)));
				vgaRegPkg::REG_V_SYNC: vSyncCmp <= VW'(mergeWrite(32'(vSyncCmp)));
				vgaRegPkg::REG_V_WHOLE: vWholeCmp <= VW'(mergeWrite(32'(vWholeCmp)));
				vgaRegPkg::REG_CONFIG: configWord.raw <= 10'(mergeWrite(32'(configWord.raw)));
				default: ;
			endcase
		end
	end

	// Read-back, zero extended
	always_comb begin
		regHit = blockSelected;
		readValue = '1;
		case (regOffset)
			vgaRegPkg::REG_H_VISIBLE: readValue = 32'(hVisibleCmp);
			vgaRegPkg::REG_H_FRONT: readValue = 32'(hFrontCmp);
			vgaRegPkg::REG_H_SYNC: readValue = 32'(hSyncCmp);
			vgaRegPkg::REG_H_WHOLE: readValue = 32'(hWholeCmp);
			vgaRegPkg::REG_V_VISIBLE: readValue = 32'(vVisibleCmp);
			vgaRegPkg::REG_V_FRONT: readValue = 32'(vFrontCmp);
			vgaRegPkg::REG_V_SYNC: readValue = 32'(vSyncCmp);
			vgaRegPkg::REG_V_WHOLE: readValue = 32'(vWholeCmp);
			vgaRegPkg::REG_CONFIG: readValue = 32'(configWord.raw);
			default: regHit = 1'b0;
		endcase
	end

	// Unmapped offsets and other blocks read as all ones
	assign busDataRead = regHit ? readValue : '1;
	assign requestOutput = busOe && regHit;

	assign horizontalPixelSize = configWord.fields.horizontalPixelSize;
	assign verticalPixelSize = configWord.fields.verticalPixelSize;
	assign drawMode = configWord.fields.drawMode;

endmodule

`default_nettype wire

// ==== source/pixelAddressGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixelAddressGen #(
	parameter int ADDRESS_BITS = 13
) (
	input wire vga_clk,
	input wire rstN,
	input wire hVisible,
	input wire vVisible,
	input wire lineEnd,
	input wire frameEnd,
	input wire [3:0] horizontalPixelSize,
	input wire [3:0] verticalPixelSize,
	input wire [1:0] drawMode,
	output logic [ADDRESS_BITS-1:0] memAddress,
	output logic loadPixel,
	output logic [vgaPixelPkg::SUB_PIXEL_BITS-1:0] subPixel
);
	localparam int HB = vgaPixelPkg::HORIZONTAL_BITS;
	localparam int VB = vgaPixelPkg::VERTICAL_BITS;
	localparam int SB = vgaPixelPkg::SUB_PIXEL_BITS;
	localparam logic [SB-1:0] LAST_SUB_PIXEL = SB'(vgaPixelPkg::PIXELS_PER_WORD - 1);

	logic [3:0] hStretch;
	logic [3:0] vStretch;
	logic [SB-1:0] subCount;
	logic [HB-1:0] wordIndex;
	logic [VB-1:0] rowIndex;
	logic [ADDRESS_BITS-3:0] linearWord;
	logic wordStart;
	logic [ADDRESS_BITS-1:0] rawAddress;
	logic [ADDRESS_BITS-1:0] tightAddress;

	// First cycle of a word inside the visible frame
	assign wordStart = hVisible && vVisible && hStretch == '0 && subCount == '0;
	assign rawAddress = ADDRESS_BITS'({rowIndex, wordIndex, 2'b00});
	assign tightAddress = {linearWord, 2'b00};

	// Position within the line, held at zero through horizontal blanking
	always_ff @(posedge vga_clk) begin
		if (!rstN || !hVisible || lineEnd) begin
			hStretch <= '0;
			subCount <= '0;
			wordIndex <= '0;
		end else begin
			if (wordStart) begin
				wordIndex <= wordIndex + 1'b1;
			end
			if (hStretch == horizontalPixelSize) begin
				hStretch <= '0;
				subCount <= (subCount == LAST_SUB_PIXEL) ? '0 : subCount + 1'b1;
			end else begin
				hStretch <= hStretch + 1'b1;
			end
		end
	end

	// Row advances once every verticalPixelSize+1 visible lines
	always_ff @(posedge vga_clk) begin
		if (!rstN || frameEnd || (lineEnd && !vVisible)) begin
			rowIndex <= '0;
			vStretch <= '0;
		end else if (lineEnd) begin
			if (vStretch == verticalPixelSize) begin
				vStretch <= '0;
				rowIndex <= rowIndex + 1'b1;
			end else begin
				vStretch <= vStretch + 1'b1;
			end
		end
	end

	// Tight mode word pointer, next word to fetch
	always_ff @(posedge vga_clk) begin
		if (!rstN || frameEnd) begin
			linearWord <= '0;
		end else if (wordStart) begin
			linearWord <= linearWord + 1'b1;
		end
	end

	// Address, strobe and sub-pixel leave together one cycle after wordStart
	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			memAddress <= '0;
			loadPixel <= 1'b0;
			subPixel <= '0;
		end else begin
			loadPixel <= wordStart;
			subPixel <= subCount;
			if (wordStart) begin
				case (drawMode)
					vgaPixelPkg::DRAW_TIGHT: memAddress <= tightAddress;
					// Reserved codes fall back to raw
					default: memAddress <= rawAddress;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/pixelOutput.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixelOutput (
	input wire vga_clk,
	input wire rstN,
	input wire loadPixel,
	input wire [vgaPixelPkg::SUB_PIXEL_BITS-1:0] subPixel,
	input wire hSyncRaw,
	input wire vSyncRaw,
	input wire [31:0] memData,
	output logic [1:0] vgaR,
	output logic [1:0] vgaG,
	output logic [1:0] vgaB,
	output logic vgaHsync,
	output logic vgaVsync
);
	localparam int CB = vgaPixelPkg::COLOUR_BITS;

	logic loadDelay;
	logic [vgaPixelPkg::SUB_PIXEL_BITS-1:0] subStage1;
	logic [vgaPixelPkg::SUB_PIXEL_BITS-1:0] subStage2;
	logic [31:0] pixelWord;
	logic [1:0] hSyncDelay;
	logic [1:0] vSyncDelay;
	logic [CB-1:0] pixel;

	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			loadDelay <= 1'b0;
			subStage1 <= '0;
			subStage2 <= '0;
			pixelWord <= '0;
			hSyncDelay <= '1;
			vSyncDelay <= '1;
		end else begin
			// memData is valid the cycle after loadPixel
			loadDelay <= loadPixel;
			if (loadDelay) begin
				pixelWord <= memData;
			end
			subStage1 <= subPixel;
			subStage2 <= subStage1;
			hSyncDelay <= {hSyncDelay[0], hSyncRaw};
			vSyncDelay <= {vSyncDelay[0], vSyncRaw};
		end
	end

	// Field 0 sits in the low bits of the word
	assign pixel = pixelWord[CB * subStage2 +: CB];
	assign vgaR = pixel[1:0];
	assign vgaG = pixel[3:2];
	assign vgaB = pixel[5:4];
	assign vgaHsync = hSyncDelay[1];
	assign vgaVsync = vSyncDelay[1];

endmodule

`default_nettype wire

// ==== source/scanCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

module scanCounter #(
	parameter int H_BITS = 11,
	parameter int V_BITS = 10
) (
	input wire vga_clk,
	input wire rstN,
	input wire [H_BITS-1:0] hWholeCmp,
	input wire [V_BITS-1:0] vWholeCmp,
	output logic [H_BITS-1:0] hCount,
	output logic [V_BITS-1:0] vCount,
	output logic lineEnd,
	output logic frameEnd
);
	// Greater-or-equal also pulls back a count left past a shortened line
	assign lineEnd = hCount >= hWholeCmp;
	assign frameEnd = lineEnd && (vCount >= vWholeCmp);

	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			// One vertical step per line
			if (frameEnd) begin
				vCount <= '0;
			end else begin
				vCount <= vCount + 1'b1;
			end
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/syncFsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module syncFsm (
	input wire vga_clk,
	input wire rstN,
	input wire [vgaRegPkg::H_WIDTH-1:0] hCount,
	input wire [vgaRegPkg::V_WIDTH-1:0] vCount,
	input wire lineEnd,
	input wire frameEnd,
	input wire [vgaRegPkg::H_WIDTH-1:0] hVisibleCmp,
	input wire [vgaRegPkg::H_WIDTH-1:0] hFrontCmp,
	input wire [vgaRegPkg::H_WIDTH-1:0] hSyncCmp,
	input wire [vgaRegPkg::V_WIDTH-1:0] vVisibleCmp,
	input wire [vgaRegPkg::V_WIDTH-1:0] vFrontCmp,
	input wire [vgaRegPkg::V_WIDTH-1:0] vSyncCmp,
	output logic hVisible,
	output logic vVisible,
	output logic hSyncRaw,
	output logic vSyncRaw
);
	localparam logic [1:0] PHASE_VISIBLE = 2'd0;
	localparam logic [1:0] PHASE_FRONT = 2'd1;
	localparam logic [1:0] PHASE_SYNC = 2'd2;
	localparam logic [1:0] PHASE_BACK = 2'd3;

	logic [1:0] hPhase;
	logic [1:0] vPhase;

	// Shared step for both axes, the whole-period end restarts from any phase
	function automatic logic [1:0] nextPhase(input logic [1:0] phase, input logic visibleEnd,
		input logic frontEnd, input logic syncEnd, input logic wholeEnd);
		logic [1:0] next;
		next = phase;
		if (wholeEnd) begin
			next = PHASE_VISIBLE;
		end else begin
			case (phase)
				PHASE_VISIBLE: next = visibleEnd ? PHASE_FRONT : phase;
				PHASE_FRONT: next = frontEnd ? PHASE_SYNC : phase;
				PHASE_SYNC: next = syncEnd ? PHASE_BACK : phase;
				default: next = phase;
			endcase
		end
		return next;
	endfunction

	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			hPhase <= PHASE_VISIBLE;
			vPhase <= PHASE_VISIBLE;
		end else begin
			hPhase <= nextPhase(hPhase, hCount == hVisibleCmp, hCount == hFrontCmp,
				hCount == hSyncCmp, lineEnd);
			// Vertical phase only moves at the end of a line
			if (lineEnd) begin
				vPhase <= nextPhase(vPhase, vCount == vVisibleCmp, vCount == vFrontCmp,
					vCount == vSyncCmp, frameEnd);
			end
		end
	end

	assign hVisible = hPhase == PHASE_VISIBLE;
	assign vVisible = vPhase == PHASE_VISIBLE;
	// Sync is active low
	assign hSyncRaw = hPhase != PHASE_SYNC;
	assign vSyncRaw = vPhase != PHASE_SYNC;

endmodule

`default_nettype wire

// ==== source/vgaController.sv ====
`timescale 1ns/10ps
`default_nettype none

module vgaController #(
	parameter int ADDRESS_BITS = 13
) (
	input wire vga_clk,
	input wire rstN,
	input wire busWe,
	input wire busOe,
	input wire [23:0] busAddress,
	input wire [3:0] busByteSelect,
	input wire [31:0] busDataWrite,
	output logic [31:0] busDataRead,
	output logic requestOutput,
	output logic [ADDRESS_BITS-1:0] memAddress,
	input wire [31:0] memData,
	output logic [1:0] vgaR,
	output logic [1:0] vgaG,
	output logic [1:0] vgaB,
	output logic vgaHsync,
	output logic vgaVsync
);
	// Sync timing compares
	logic [vgaRegPkg::H_WIDTH-1:0] hVisibleCmp;
	logic [vgaRegPkg::H_WIDTH-1:0] hFrontCmp;
	logic [vgaRegPkg::H_WIDTH-1:0] hSyncCmp;
	logic [vgaRegPkg::H_WIDTH-1:0] hWholeCmp;
	logic [vgaRegPkg::V_WIDTH-1:0] vVisibleCmp;
	logic [vgaRegPkg::V_WIDTH-1:0] vFrontCmp;
	logic [vgaRegPkg::V_WIDTH-1:0] vSyncCmp;
	logic [vgaRegPkg::V_WIDTH-1:0] vWholeCmp;

	logic [3:0] horizontalPixelSize;
	logic [3:0] verticalPixelSize;
	logic [1:0] drawMode;

	logic [vgaRegPkg::H_WIDTH-1:0] hCount;
	logic [vgaRegPkg::V_WIDTH-1:0] vCount;
	logic lineEnd;
	logic frameEnd;

	logic hVisible;
	logic vVisible;
	logic hSyncRaw;
	logic vSyncRaw;

	logic loadPixel;
	logic [vgaPixelPkg::SUB_PIXEL_BITS-1:0] subPixel;

	configRegisters configRegisters_inst (
		.vga_clk(vga_clk), .rstN(rstN),
		.busWe(busWe), .busOe(busOe), .busAddress(busAddress),
		.busByteSelect(busByteSelect), .busDataWrite(busDataWrite),
		.busDataRead(busDataRead), .requestOutput(requestOutput),
		.hVisibleCmp(hVisibleCmp), .hFrontCmp(hFrontCmp),
		.hSyncCmp(hSyncCmp), .hWholeCmp(hWholeCmp),
		.vVisibleCmp(vVisibleCmp), .vFrontCmp(vFrontCmp),
		.vSyncCmp(vSyncCmp), .vWholeCmp(vWholeCmp),
		.horizontalPixelSize(horizontalPixelSize),
		.verticalPixelSize(verticalPixelSize), .drawMode(drawMode)
	);

	scanCounter #(
		.H_BITS(vgaRegPkg::H_WIDTH),
		.V_BITS(vgaRegPkg::V_WIDTH)
	) scanCounter_inst (
		.vga_clk(vga_clk), .rstN(rstN),
		.hWholeCmp(hWholeCmp), .vWholeCmp(vWholeCmp),
		.hCount(hCount), .vCount(vCount),
		.lineEnd(lineEnd), .frameEnd(frameEnd)
	);

	syncFsm syncFsm_inst (
		.vga_clk(vga_clk), .rstN(rstN),
		.hCount(hCount), .vCount(vCount),
		.lineEnd(lineEnd), .frameEnd(frameEnd),
		.hVisibleCmp(hVisibleCmp), .hFrontCmp(hFrontCmp), .hSyncCmp(hSyncCmp),
		.vVisibleCmp(vVisibleCmp), .vFrontCmp(vFrontCmp), .vSyncCmp(vSyncCmp),
		.hVisible(hVisible), .vVisible(vVisible),
		.hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw)
	);

	pixelAddressGen #(
		.ADDRESS_BITS(ADDRESS_BITS)
	) pixelAddressGen_inst (
		.vga_clk(vga_clk), .rstN(rstN),
		.hVisible(hVisible), .vVisible(vVisible),
		.lineEnd(lineEnd), .frameEnd(frameEnd),
		.horizontalPixelSize(horizontalPixelSize),
		.verticalPixelSize(verticalPixelSize), .drawMode(drawMode),
		.memAddress(memAddress), .loadPixel(loadPixel), .subPixel(subPixel)
	);

	pixelOutput pixelOutput_inst (
		.vga_clk(vga_clk), .rstN(rstN),
		.loadPixel(loadPixel), .subPixel(subPixel),
		.hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw), .memData(memData),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB),
		.vgaHsync(vgaHsync), .vgaVsync(vgaVsync)
	);

endmodule

`default_nettype wire

// ==== source/vgaPixelPkg.sv ====
`default_nettype none

package vgaPixelPkg;

	// One pixel is 2 bits each of red, green and blue
	localparam int COLOUR_BITS = 6;
	localparam int PIXELS_PER_WORD = 5;
	localparam int SUB_PIXEL_BITS = 3;

	// Raw mode address is {row, word, 2'b00}
	localparam int VERTICAL_BITS = 7;
	localparam int HORIZONTAL_BITS = 4;

	typedef enum logic [1:0] {
		DRAW_RAW = 2'b00,
		DRAW_TIGHT = 2'b01,
		DRAW_RESERVED_2 = 2'b10,
		DRAW_RESERVED_3 = 2'b11
	} drawMode_e;

endpackage

`default_nettype wire

// ==== source/vgaRegPkg.sv ====
`default_nettype none

package vgaRegPkg;

	// Block select on busAddress[23:12]
	localparam logic [11:0] CONFIG_BASE = 12'h010;

	// Register offsets on busAddress[11:0]
	localparam logic [11:0] REG_H_VISIBLE = 12'h000;
	localparam logic [11:0] REG_H_FRONT = 12'h004;
	localparam logic [11:0] REG_H_SYNC = 12'h008;
	localparam logic [11:0] REG_H_WHOLE = 12'h00C;
	localparam logic [11:0] REG_V_VISIBLE = 12'h010;
	localparam logic [11:0] REG_V_FRONT = 12'h014;
	localparam logic [11:0] REG_V_SYNC = 12'h018;
	localparam logic [11:0] REG_V_WHOLE = 12'h01C;
	localparam logic [11:0] REG_CONFIG = 12'h020;

	localparam int H_WIDTH = 11;
	localparam int V_WIDTH = 10;

	// 800 x 600 at 60 Hz, each value is the last count of its phase
	localparam logic [H_WIDTH-1:0] DEFAULT_H_VISIBLE = 799;
	localparam logic [H_WIDTH-1:0] DEFAULT_H_FRONT = 839;
	localparam logic [H_WIDTH-1:0] DEFAULT_H_SYNC = 967;
	localparam logic [H_WIDTH-1:0] DEFAULT_H_WHOLE = 1055;
	localparam logic [V_WIDTH-1:0] DEFAULT_V_VISIBLE = 599;
	localparam logic [V_WIDTH-1:0] DEFAULT_V_FRONT = 600;
	localparam logic [V_WIDTH-1:0] DEFAULT_V_SYNC = 604;
	localparam logic [V_WIDTH-1:0] DEFAULT_V_WHOLE = 627;

	// Both pixel sizes 0xA, raw draw mode
	localparam logic [9:0] DEFAULT_CONFIG = 10'h0AA;

	typedef struct packed {
		logic [1:0] drawMode;
		logic [3:0] verticalPixelSize;
		logic [3:0] horizontalPixelSize;
	} configFields_t;

	// Same word seen as bus data or as its fields
	typedef union packed {
		logic [9:0] raw;
		configFields_t fields;
	} configWord_u;

endpackage

`default_nettype wire

// ==== tb/vgaClockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module vgaClockGen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic vga_clk,
	output logic rstN
);
	initial begin
		vga_clk = 1'b0;
		forever #(PERIOD / 2) vga_clk = ~vga_clk;
	end

	// Release reset just after a rising edge
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge vga_clk);
		#2 rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/vgaControllerTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vgaControllerTb;
	logic vga_clk;
	logic rstN;
	logic busWe;
	logic busOe;
	logic [23:0] busAddress;
	logic [3:0] busByteSelect;
	logic [31:0] busDataWrite;
	logic [31:0] busDataRead;
	logic requestOutput;
	logic [12:0] memAddress;
	logic [31:0] memData = '0;
	logic [1:0] vgaR;
	logic [1:0] vgaG;
	logic [1:0] vgaB;
	logic vgaHsync;
	logic vgaVsync;
	logic [15:0] lfsrState = 16'd37;
	int errorCount = 0;
	int timeoutCount = 0;
	int checkCount = 0;

	vgaClockGen #(.PERIOD(40), .RESET_CYCLES(16)) vgaClockGen_inst (
		.vga_clk(vga_clk), .rstN(rstN));

	vgaController #(.ADDRESS_BITS(13)) vgaController_inst (
		.vga_clk(vga_clk), .rstN(rstN), .busWe(busWe), .busOe(busOe),
		.busAddress(busAddress), .busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite), .busDataRead(busDataRead),
		.requestOutput(requestOutput), .memAddress(memAddress), .memData(memData),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB), .vgaHsync(vgaHsync), .vgaVsync(vgaVsync));

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Memory contents as a hash of the address
	function automatic logic [31:0] memWord(input logic [12:0] address);
		logic [15:0] state;
		logic [31:0] value;
		state = {3'b000, address} ^ 16'hB5C3;
		value = '0;
		for (int i = 0; i < 32; i++) begin
			state = lfsrNext(state);
			value = {value[30:0], state[0]};
		end
		return value;
	endfunction

	// One cycle read latency
	always @(posedge vga_clk) begin
		memData <= #2 memWord(memAddress);
	end

	task automatic nextCycle();
		@(posedge vga_clk);
		#2;
	endtask

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic busWrite(input logic [23:0] address, input logic [3:0] byteSelect,
		input logic [31:0] data);
		nextCycle();
		busWe = 1'b1;
		busAddress = address;
		busByteSelect = byteSelect;
		busDataWrite = data;
		nextCycle();
		busWe = 1'b0;
	endtask

	task automatic busRead(input logic [23:0] address, output logic [31:0] data,
		output logic request);
		nextCycle();
		busOe = 1'b1;
		busAddress = address;
		#10;
		data = busDataRead;
		request = requestOutput;
		nextCycle();
		busOe = 1'b0;
	endtask

	task automatic waitSync(input bit vertical, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while (((vertical ? vgaVsync : vgaHsync) !== level) && cycles < limit) begin
			nextCycle();
			cycles++;
		end
		if ((vertical ? vgaVsync : vgaHsync) !== level) begin
			timeoutCount++;
			$display("Timeout: %s sync never went to %b", vertical ? "vertical" : "horizontal",
				level);
		end
	endtask

	// Period and low width of one sync output in cycles
	task automatic measureSync(input bit vertical, input int limit, output int lowCycles,
		output int period);
		int highCycles;
		waitSync(vertical, 1'b1, limit, highCycles);
		waitSync(vertical, 1'b0, limit, highCycles);
		waitSync(vertical, 1'b1, limit, lowCycles);
		waitSync(vertical, 1'b0, limit, highCycles);
		period = lowCycles + highCycles;
	endtask

	// Follows one frame of fetches with a 40 x 10 visible area and 16 blank cycles per line
	task automatic scanFrame(input bit tight, input int hps, input int vps);
		int step;
		int total;
		int found;
		int cycle;
		int interval;
		int lineNo;
		int wordNo;
		int pendingAt;
		int shownStart;
		int waited;
		bit shown;
		logic [12:0] lastAddress;
		logic [12:0] expAddress;
		logic [31:0] pendingWord;
		logic [31:0] shownWord;
		string name;
		step = 5 * (hps + 1);
		total = 10 * (40 / step);
		name = tight ? "tightAddress" : "rawAddress";
		found = 0;
		cycle = 0;
		interval = 0;
		lineNo = 0;
		wordNo = 0;
		pendingAt = -1;
		shownStart = 0;
		shown = 1'b0;
		pendingWord = '0;
		shownWord = '0;
		waitSync(1'b1, 1'b1, 4000, waited);
		waitSync(1'b1, 1'b0, 4000, waited);
		lastAddress = memAddress;
		while (cycle < 2000 && (found < total || shown || pendingAt >= 0)) begin
			nextCycle();
			cycle++;
			interval++;
			if (memAddress !== lastAddress) begin
				if (found > 0) begin
					if (interval == step + 16) begin
						lineNo++;
						wordNo = 0;
					end else if (interval == step) begin
						wordNo++;
					end else begin
						errorCount++;
						$display("ERR %s interval expected %0d actual %0d", name, step, interval);
					end
				end
				expAddress = tight ? 13'(found * 4) : 13'((lineNo / (vps + 1)) * 64 + wordNo * 4);
				compareValue(name, 32'(expAddress), 32'(memAddress));
				pendingWord = memWord(memAddress);
				pendingAt = cycle + 2;
				found++;
				interval = 0;
				lastAddress = memAddress;
			end
			if (cycle == pendingAt) begin
				shown = 1'b1;
				shownWord = pendingWord;
				shownStart = cycle;
				pendingAt = -1;
			end
			if (shown && cycle - shownStart >= step) begin
				shown = 1'b0;
			end
			if (shown) begin
				compareValue("colour", 32'(shownWord[6 * ((cycle - shownStart) / (hps + 1)) +: 6]),
					32'({vgaB, vgaG, vgaR}));
			end
		end
		if (found != total) begin
			timeoutCount++;
			$display("%s saw %0d words in a frame instead of %0d", name, found, total);
		end
	endtask

	initial begin
		logic [31:0] regModel [9];
		logic [31:0] widthMask [9];
		logic [31:0] data;
		logic [31:0] byteMask;
		logic [3:0] byteSelect;
		logic request;
		int index;
		int waited;
		int lowCycles;
		int period;
		int hps;
		int vps;
		vgaRegPkg::configWord_u configValue;
		busWe = 1'b0;
		busOe = 1'b0;
		busAddress = '0;
		busByteSelect = '0;
		busDataWrite = '0;
		regModel = '{32'(vgaRegPkg::DEFAULT_H_VISIBLE), 32'(vgaRegPkg::DEFAULT_H_FRONT),
			32'(vgaRegPkg::DEFAULT_H_SYNC), 32'(vgaRegPkg::DEFAULT_H_WHOLE),
			32'(vgaRegPkg::DEFAULT_V_VISIBLE), 32'(vgaRegPkg::DEFAULT_V_FRONT),
			32'(vgaRegPkg::DEFAULT_V_SYNC), 32'(vgaRegPkg::DEFAULT_V_WHOLE),
			32'(vgaRegPkg::DEFAULT_CONFIG)};
		widthMask = '{32'h7FF, 32'h7FF, 32'h7FF, 32'h7FF, 32'h3FF, 32'h3FF, 32'h3FF, 32'h3FF,
			32'h3FF};
		waited = 0;
		while (rstN !== 1'b1 && waited < 100) begin
			nextCycle();
			waited++;
		end
		if (rstN !== 1'b1) begin
			timeoutCount++;
			$display("Timeout: reset was never released");
		end

		// Reset defaults
		for (int i = 0; i < 9; i++) begin
			busRead({12'h010, 12'(i * 4)}, data, request);
			compareValue("resetValue", regModel[i], data);
			compareValue("resetRequest", 32'(1'b1), 32'(request));
		end

		// Byte-select writes against the merge model
		for (int n = 0; n < 40; n++) begin
			index = randomBits(4) % 9;
			byteSelect = 4'(randomBits(4));
			data = randomBits(32);
			byteMask = {{8{byteSelect[3]}}, {8{byteSelect[2]}}, {8{byteSelect[1]}},
				{8{byteSelect[0]}}};
			busWrite({12'h010, 12'(index * 4)}, byteSelect, data);
			regModel[index] = ((regModel[index] & ~byteMask) | (data & byteMask))
				& widthMask[index];
			busRead({12'h010, 12'(index * 4)}, data, request);
			compareValue("byteWrite", regModel[index], data);
			compareValue("writeRequest", 32'(1'b1), 32'(request));
		end
		for (int n = 0; n < 8; n++) begin
			busRead({12'(12'h020 + randomBits(4)), 12'(randomBits(12))}, data, request);
			compareValue("otherBlock", 32'hFFFF_FFFF, data);
			compareValue("otherRequest", 32'(1'b0), 32'(request));
			busRead({12'h010, 12'(12'h024 + randomBits(8))}, data, request);
			compareValue("unmapped", 32'hFFFF_FFFF, data);
			compareValue("unmappedRequest", 32'(1'b0), 32'(request));
		end

		// Small screen of 40 x 10 pixels with 56 cycles per line and 16 lines
		busWrite({12'h010, vgaRegPkg::REG_H_VISIBLE}, 4'hF, 32'd39);
		busWrite({12'h010, vgaRegPkg::REG_H_FRONT}, 4'hF, 32'd43);
		busWrite({12'h010, vgaRegPkg::REG_H_SYNC}, 4'hF, 32'd47);
		busWrite({12'h010, vgaRegPkg::REG_H_WHOLE}, 4'hF, 32'd55);
		busWrite({12'h010, vgaRegPkg::REG_V_VISIBLE}, 4'hF, 32'd9);
		busWrite({12'h010, vgaRegPkg::REG_V_FRONT}, 4'hF, 32'd10);
		busWrite({12'h010, vgaRegPkg::REG_V_SYNC}, 4'hF, 32'd12);
		busWrite({12'h010, vgaRegPkg::REG_V_WHOLE}, 4'hF, 32'd15);
		busWrite({12'h010, vgaRegPkg::REG_CONFIG}, 4'hF, 32'd0);
		waitSync(1'b1, 1'b0, 4000, waited);

		measureSync(1'b0, 200, lowCycles, period);
		compareValue("hsyncLow", 32'd4, 32'(lowCycles));
		compareValue("hsyncPeriod", 32'd56, 32'(period));
		measureSync(1'b1, 4000, lowCycles, period);
		compareValue("vsyncLow", 32'd112, 32'(lowCycles));
		compareValue("vsyncPeriod", 32'd896, 32'(period));

		// Pixel sizes that split a 40-cycle line into whole words
		for (int n = 0; n < 3; n++) begin
			hps = (1 << randomBits(2)) - 1;
			vps = randomBits(2);
			configValue.fields.horizontalPixelSize = 4'(hps);
			configValue.fields.verticalPixelSize = 4'(vps);
			configValue.fields.drawMode = vgaPixelPkg::DRAW_TIGHT;
			busWrite({12'h010, vgaRegPkg::REG_CONFIG}, 4'hF, 32'(configValue.raw));
			scanFrame(1'b1, hps, vps);
			hps = randomBits(1);
			vps = randomBits(2);
			configValue.fields.horizontalPixelSize = 4'(hps);
			configValue.fields.verticalPixelSize = 4'(vps);
			configValue.fields.drawMode = vgaPixelPkg::DRAW_RAW;
			busWrite({12'h010, vgaRegPkg::REG_CONFIG}, 4'hF, 32'(configValue.raw));
			scanFrame(1'b0, hps, vps);
		end

		$display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/vgaController_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module vgaControllerAssert (
	input wire vga_clk,
	input wire rstN,
	input wire busOe,
	input wire [23:0] busAddress,
	input wire requestOutput,
	input wire loadPixel,
	input wire vgaHsync,
	input wire vgaVsync
);
	// High only for a read of one of the nine mapped words
	requestDecode: assert property (@(posedge vga_clk)
		requestOutput == (busOe && busAddress[23:12] == vgaRegPkg::CONFIG_BASE
			&& busAddress[11:0] <= vgaRegPkg::REG_CONFIG && busAddress[1:0] == 2'b00))
		else $error("requestOutput does not follow busOe and the register map");

	loadIsPulse: assert property (@(posedge vga_clk) disable iff (!rstN)
		loadPixel |=> !loadPixel)
		else $error("loadPixel held high for more than one cycle");

	// Outputs have taken their reset value after the first reset edge
	syncIdleInReset: assert property (@(posedge vga_clk)
		!rstN ##1 !rstN |-> vgaHsync && vgaVsync)
		else $error("sync output low during reset");

endmodule

bind vgaController vgaControllerAssert vgaControllerAssert_inst (
	.vga_clk(vga_clk), .rstN(rstN), .busOe(busOe), .busAddress(busAddress),
	.requestOutput(requestOutput), .loadPixel(loadPixel),
	.vgaHsync(vgaHsync), .vgaVsync(vgaVsync)
);

`default_nettype wire
